//--- logic/rv_core_pkg.sv
package rv_core_pkg;

	typedef logic [63:0] xlen_t;
	typedef logic [4:0]  reg_addr_t;

	// major opcodes; MUL sits under OP and is picked out by funct7
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_SYSTEM = 7'b1110011
	} opcode_t;

	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
	localparam logic [6:0] FUNCT7_ALT    = 7'b0100000; // sub / sra

	// funct3 of the integer ops
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRL = 3'b101;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_MUL,
		ALU_PASS
	} alu_op_t;

	typedef enum logic {
		MEM_WORD   = 1'b0,
		MEM_DOUBLE = 1'b1
	} mem_size_t;

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		opcode_t    opcode;
	} rtype_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		opcode_t     opcode;
	} itype_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_t    opcode;
	} stype_t;

	// one instruction word, read through the view its opcode calls for
	typedef union packed {
		rtype_t r;
		itype_t i;
		stype_t s;
	} instr_u;

endpackage

//--- logic/rv_decode.sv
module rv_decode import rv_core_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      instr_vld_i,
	input  instr_u    instr_i,
	input  logic      hold_i,     // execute busy with a multiply
	input  reg_addr_t ex_rd_i,
	input  logic      ex_pend_i,
	input  reg_addr_t mem_rd_i,
	input  logic      mem_pend_i,
	input  logic      wb_en_i,
	input  reg_addr_t wb_rd_i,
	input  xlen_t     wb_data_i,
	output logic      stall_o,
	output logic      vld_o,
	output alu_op_t   alu_op_o,
	output xlen_t     src1_o,
	output xlen_t     src2_o,
	output reg_addr_t rd_o,
	output logic      wen_o,
	output logic      is_load_o,
	output logic      is_store_o,
	output mem_size_t size_o,
	output xlen_t     store_data_o,
	output logic      ebreak_o
);

	xlen_t     regs [1:31];
	reg_addr_t rs1;
	reg_addr_t rs2;
	xlen_t     rs1_val;
	xlen_t     rs2_val;
	xlen_t     imm_i;
	xlen_t     imm_s;
	alu_op_t   dec_op;
	xlen_t     dec_src2;
	logic      dec_wen;
	logic      dec_load;
	logic      dec_store;
	logic      dec_ebrk;
	mem_size_t dec_size;
	logic      use_rs1;
	logic      use_rs2;
	logic      own_pend;
	logic      hazard;
	logic      take;

	function automatic alu_op_t f3_op(logic [2:0] f3, logic alt);
		case (f3)
			F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
			F3_SLL:  return ALU_SLL;
			F3_SLT:  return ALU_SLT;
			F3_XOR:  return ALU_XOR;
			F3_SRL:  return alt ? ALU_SRA : ALU_SRL;
			F3_OR:   return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	function automatic logic dep(reg_addr_t rs, logic used, reg_addr_t prd, logic pend);
		return used && pend && rs != '0 && rs == prd;
	endfunction

	assign rs1   = instr_i.r.rs1;
	assign rs2   = instr_i.r.rs2;
	assign imm_i = {{52{instr_i.i.imm[11]}}, instr_i.i.imm};
	assign imm_s = {{52{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};

	// write-first read, x0 is always zero
	assign rs1_val = (rs1 == '0) ? '0 : (wb_en_i && wb_rd_i == rs1) ? wb_data_i : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : (wb_en_i && wb_rd_i == rs2) ? wb_data_i : regs[rs2];

	always_comb begin
		dec_op    = ALU_ADD;
		dec_src2  = imm_i;
		dec_wen   = 1'b0;
		dec_load  = 1'b0;
		dec_store = 1'b0;
		dec_ebrk  = 1'b0;
		use_rs1   = 1'b0;
		use_rs2   = 1'b0;
		dec_size  = instr_i.i.funct3[0] ? MEM_DOUBLE : MEM_WORD; // 011 double, 010 word
		case (instr_i.r.opcode)
			OPC_OP: begin
				use_rs1  = 1'b1;
				use_rs2  = 1'b1;
				dec_wen  = 1'b1;
				dec_src2 = rs2_val;
				if (instr_i.r.funct7 == FUNCT7_MULDIV) begin
					dec_op = ALU_MUL;
				end else begin
					dec_op = f3_op(instr_i.r.funct3, instr_i.r.funct7 == FUNCT7_ALT);
				end
			end
			OPC_OP_IMM: begin
				use_rs1 = 1'b1;
				dec_wen = 1'b1;
				dec_op  = f3_op(instr_i.i.funct3, 1'b0);
			end
			OPC_LOAD: begin
				use_rs1  = 1'b1;
				dec_wen  = 1'b1;
				dec_load = 1'b1;
			end
			OPC_STORE: begin
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				dec_store = 1'b1;
				dec_src2  = imm_s;
			end
			OPC_SYSTEM: begin
				dec_ebrk = 1'b1;
				dec_op   = ALU_PASS;
			end
			default: ;
		endcase
	end

	// interlock against our own register, execute and the ex/mem register
	assign own_pend = vld_o & wen_o;
	assign hazard   = instr_vld_i & (
		dep(rs1, use_rs1, rd_o, own_pend) | dep(rs2, use_rs2, rd_o, own_pend) |
		dep(rs1, use_rs1, ex_rd_i, ex_pend_i) | dep(rs2, use_rs2, ex_rd_i, ex_pend_i) |
		dep(rs1, use_rs1, mem_rd_i, mem_pend_i) | dep(rs2, use_rs2, mem_rd_i, mem_pend_i));
	assign stall_o = hazard | hold_i;
	assign take    = instr_vld_i & ~stall_o;

	always_ff @(posedge clk) begin
		if (wb_en_i && wb_rd_i != '0) begin
			regs[wb_rd_i] <= wb_data_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_o      <= 1'b0;
			wen_o      <= 1'b0;
			is_load_o  <= 1'b0;
			is_store_o <= 1'b0;
			ebreak_o   <= 1'b0;
		end else if (!hold_i) begin // a stalled slot goes out as a bubble
			vld_o      <= take;
			wen_o      <= take & dec_wen;
			is_load_o  <= take & dec_load;
			is_store_o <= take & dec_store;
			ebreak_o   <= take & dec_ebrk;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			alu_op_o     <= dec_op;
			src1_o       <= rs1_val;
			src2_o       <= dec_src2;
			rd_o         <= instr_i.r.rd;
			size_o       <= dec_size;
			store_data_o <= rs2_val;
		end
	end

	a_no_issue_on_hazard: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(vld_o) |-> !$past(hazard));

endmodule

//--- logic/rv_execute.sv
module rv_execute import rv_core_pkg::*; #(
	parameter int MUL_STEP = 8
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      vld_i,
	input  alu_op_t   alu_op_i,
	input  xlen_t     src1_i,
	input  xlen_t     src2_i,
	input  reg_addr_t rd_i,
	input  logic      wen_i,
	input  logic      is_load_i,
	input  logic      is_store_i,
	input  mem_size_t size_i,
	input  xlen_t     store_data_i,
	input  logic      ebreak_i,
	output logic      vld_o,
	output xlen_t     res_o,
	output reg_addr_t rd_o,
	output logic      wen_o,
	output logic      is_load_o,
	output logic      is_store_o,
	output mem_size_t size_o,
	output logic [7:0] wmask_o,
	output xlen_t     store_data_o,
	output logic      ebreak_o,
	output logic      busy_o,
	output logic      done_o,
	output logic      pend_o
);

	localparam int STEPS = 64 / MUL_STEP;
	localparam int CNT_W = $clog2(STEPS);

	xlen_t        alu_res;
	logic [5:0]   shamt;
	logic [7:0]   mask;
	xlen_t        sdata;
	logic         vld_q;
	logic         busy_q;
	xlen_t        res_q;
	xlen_t        a_q;        // multiplicand, shifted up each step
	xlen_t        b_q;        // multiplier, shifted down each step
	xlen_t        acc_q;
	xlen_t        acc_next;
	xlen_t        b_digit;
	logic [CNT_W-1:0] cnt_q;

	assign shamt = src2_i[5:0];

	always_comb begin
		case (alu_op_i)
			ALU_ADD:  alu_res = src1_i + src2_i;
			ALU_SUB:  alu_res = src1_i - src2_i;
			ALU_AND:  alu_res = src1_i & src2_i;
			ALU_OR:   alu_res = src1_i | src2_i;
			ALU_XOR:  alu_res = src1_i ^ src2_i;
			ALU_SLL:  alu_res = src1_i << shamt;
			ALU_SRL:  alu_res = src1_i >> shamt;
			ALU_SRA:  alu_res = xlen_t'($signed(src1_i) >>> shamt);
			ALU_SLT:  alu_res = {63'd0, $signed(src1_i) < $signed(src2_i)};
			ALU_PASS: alu_res = src1_i;
			default:  alu_res = '0; // MUL result comes from the iteration
		endcase
	end

	// byte lanes picked by size and address bit 2
	assign mask  = (size_i == MEM_DOUBLE) ? 8'hff : (alu_res[2] ? 8'hf0 : 8'h0f);
	assign sdata = (size_i == MEM_DOUBLE) ? store_data_i : {2{store_data_i[31:0]}};

	assign b_digit  = xlen_t'(b_q[MUL_STEP-1:0]);
	assign acc_next = acc_q + a_q * b_digit;
	assign done_o   = busy_q && cnt_q == CNT_W'(STEPS - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_q      <= 1'b0;
			busy_q     <= 1'b0;
			wen_o      <= 1'b0;
			is_load_o  <= 1'b0;
			is_store_o <= 1'b0;
			ebreak_o   <= 1'b0;
		end else if (busy_q) begin
			if (done_o) begin // product leaves this cycle
				busy_q <= 1'b0;
				vld_q  <= 1'b0;
			end
		end else begin
			vld_q      <= vld_i;
			busy_q     <= vld_i && alu_op_i == ALU_MUL;
			wen_o      <= vld_i & wen_i;
			is_load_o  <= vld_i & is_load_i;
			is_store_o <= vld_i & is_store_i;
			ebreak_o   <= vld_i & ebreak_i;
		end
	end

	always_ff @(posedge clk) begin
		if (busy_q) begin
			a_q   <= a_q << MUL_STEP;
			b_q   <= b_q >> MUL_STEP;
			acc_q <= acc_next;
			cnt_q <= cnt_q + 1'b1;
		end else if (vld_i) begin
			res_q        <= alu_res;
			rd_o         <= rd_i;
			size_o       <= size_i;
			wmask_o      <= is_store_i ? mask : 8'h00;
			store_data_o <= sdata;
			a_q          <= src1_i;
			b_q          <= src2_i;
			acc_q        <= '0;
			cnt_q        <= '0;
		end
	end

	assign vld_o  = vld_q & (~busy_q | done_o);
	assign res_o  = busy_q ? acc_next : res_q;
	assign busy_o = busy_q;
	assign pend_o = vld_q & wen_o;

	a_busy_until_done: assert property (@(posedge clk) disable iff (!rst_n)
		busy_o && !done_o |=> busy_o);
	// decode must hold its instruction while the multiplier runs
	a_no_issue_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		busy_o |=> $stable(vld_i) && $stable(src1_i));

endmodule

//--- logic/rv_ex_mem_regs.sv
module rv_ex_mem_regs import rv_core_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       vld_i,
	input  xlen_t      res_i,
	input  reg_addr_t  rd_i,
	input  logic       wen_i,
	input  logic       is_load_i,
	input  logic       is_store_i,
	input  mem_size_t  size_i,
	input  logic [7:0] wmask_i,
	input  xlen_t      store_data_i,
	input  logic       ebreak_i,
	input  logic       mul_busy_i,
	input  logic       mul_done_i,
	output logic       vld_o,
	output xlen_t      res_o,
	output reg_addr_t  rd_o,
	output logic       wen_o,
	output logic       is_load_o,
	output logic       is_store_o,
	output mem_size_t  size_o,
	output logic [7:0] wmask_o,
	output xlen_t      store_data_o,
	output logic       ebreak_o,
	output logic       pend_o
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_o        <= 1'b0;
			res_o        <= '0;
			rd_o         <= '0;
			wen_o        <= 1'b0;
			is_load_o    <= 1'b0;
			is_store_o   <= 1'b0;
			size_o       <= MEM_WORD;
			wmask_o      <= 8'h00;
			store_data_o <= '0;
			ebreak_o     <= 1'b0;
		end else if (mul_busy_i && !mul_done_i) begin
			vld_o <= 1'b0; // multiply still running, keep the rest and send a bubble
		end else begin
			vld_o        <= vld_i;
			res_o        <= res_i;
			rd_o         <= rd_i;
			wen_o        <= wen_i;
			is_load_o    <= is_load_i;
			is_store_o   <= is_store_i;
			size_o       <= size_i;
			wmask_o      <= wmask_i;
			store_data_o <= store_data_i;
			ebreak_o     <= ebreak_i;
		end
	end

	assign pend_o = vld_o & wen_o; // for the decode interlock

endmodule

//--- logic/rv_result.sv
module rv_result import rv_core_pkg::*; #(
	parameter int DMEM_WORDS = 32
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       vld_i,
	input  xlen_t      addr_i,
	input  xlen_t      data_i,
	input  reg_addr_t  rd_i,
	input  logic       wen_i,
	input  logic       is_load_i,
	input  logic       is_store_i,
	input  mem_size_t  size_i,
	input  logic [7:0] wmask_i,
	input  logic       ebreak_i,
	output logic       wb_vld_o,
	output reg_addr_t  wb_rd_o,
	output xlen_t      wb_data_o,
	output logic       halt_o
);

	localparam int IDX_W = $clog2(DMEM_WORDS);

	xlen_t            dmem [DMEM_WORDS];
	logic [IDX_W-1:0] idx;
	xlen_t            rdata;
	logic [31:0]      rword;
	xlen_t            load_val;
	logic             live;

	assign idx   = addr_i[3 +: IDX_W]; // doubleword slot, wraps at DMEM_WORDS
	assign rdata = dmem[idx];
	assign rword = addr_i[2] ? rdata[63:32] : rdata[31:0];

	assign load_val = (size_i == MEM_WORD) ? {{32{rword[31]}}, rword} : rdata;
	assign live     = vld_i & ~halt_o;  // nothing past ebreak takes effect

	always_ff @(posedge clk) begin
		if (live && is_store_i) begin
			for (int b = 0; b < 8; b++) begin
				if (wmask_i[b]) begin
					dmem[idx][b*8 +: 8] <= data_i[b*8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_vld_o <= 1'b0;
			halt_o   <= 1'b0;
		end else begin
			wb_vld_o <= live && wen_i && rd_i != '0 && !ebreak_i;
			if (live && ebreak_i) begin
				halt_o <= 1'b1; // sticky
			end
		end
	end

	always_ff @(posedge clk) begin
		if (live) begin
			wb_rd_o   <= rd_i;
			wb_data_o <= is_load_i ? load_val : addr_i;
		end
	end

	a_quiet_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
		halt_o |-> !wb_vld_o);

endmodule

//--- logic/rv_core_top.sv
module rv_core_top import rv_core_pkg::*; #(
	parameter int DMEM_WORDS = 32,
	parameter int MUL_STEP   = 8
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        instr_vld_i,
	input  logic [31:0] instr_i,
	output logic        stall_o,
	output logic        wb_vld_o,
	output reg_addr_t   wb_rd_o,
	output xlen_t       wb_data_o,
	output logic        halt_o
);

	// decode -> execute
	logic       id_vld;
	alu_op_t    id_alu_op;
	xlen_t      id_src1;
	xlen_t      id_src2;
	reg_addr_t  id_rd;
	logic       id_wen;
	logic       id_is_load;
	logic       id_is_store;
	mem_size_t  id_size;
	xlen_t      id_store_data;
	logic       id_ebreak;
	logic       decode_stall;

	// execute -> ex/mem
	logic       ex_vld;
	xlen_t      ex_res;
	reg_addr_t  ex_rd;
	logic       ex_wen;
	logic       ex_is_load;
	logic       ex_is_store;
	mem_size_t  ex_size;
	logic [7:0] ex_wmask;
	xlen_t      ex_store_data;
	logic       ex_ebreak;
	logic       ex_pend;
	logic       mul_busy;
	logic       mul_done;

	// ex/mem -> result
	logic       mem_vld;
	xlen_t      mem_addr;
	xlen_t      mem_data;
	reg_addr_t  mem_rd;
	logic       mem_wen;
	logic       mem_is_load;
	logic       mem_is_store;
	mem_size_t  mem_size;
	logic [7:0] mem_wmask;
	logic       mem_ebreak;
	logic       mem_pend;

	assign decode_stall = mul_busy;

	rv_decode u_decode (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_vld_i  (instr_vld_i),
		.instr_i      (instr_i),
		.hold_i       (decode_stall),
		.ex_rd_i      (ex_rd),
		.ex_pend_i    (ex_pend),
		.mem_rd_i     (mem_rd),
		.mem_pend_i   (mem_pend),
		.wb_en_i      (wb_vld_o),
		.wb_rd_i      (wb_rd_o),
		.wb_data_i    (wb_data_o),
		.stall_o      (stall_o),
		.vld_o        (id_vld),
		.alu_op_o     (id_alu_op),
		.src1_o       (id_src1),
		.src2_o       (id_src2),
		.rd_o         (id_rd),
		.wen_o        (id_wen),
		.is_load_o    (id_is_load),
		.is_store_o   (id_is_store),
		.size_o       (id_size),
		.store_data_o (id_store_data),
		.ebreak_o     (id_ebreak)
	);

	rv_execute #(
		.MUL_STEP (MUL_STEP)
	) u_execute (
		.clk          (clk),
		.rst_n        (rst_n),
		.vld_i        (id_vld),
		.alu_op_i     (id_alu_op),
		.src1_i       (id_src1),
		.src2_i       (id_src2),
		.rd_i         (id_rd),
		.wen_i        (id_wen),
		.is_load_i    (id_is_load),
		.is_store_i   (id_is_store),
		.size_i       (id_size),
		.store_data_i (id_store_data),
		.ebreak_i     (id_ebreak),
		.vld_o        (ex_vld),
		.res_o        (ex_res),
		.rd_o         (ex_rd),
		.wen_o        (ex_wen),
		.is_load_o    (ex_is_load),
		.is_store_o   (ex_is_store),
		.size_o       (ex_size),
		.wmask_o      (ex_wmask),
		.store_data_o (ex_store_data),
		.ebreak_o     (ex_ebreak),
		.busy_o       (mul_busy),
		.done_o       (mul_done),
		.pend_o       (ex_pend)
	);

	rv_ex_mem_regs u_ex_mem_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.vld_i        (ex_vld),
		.res_i        (ex_res),
		.rd_i         (ex_rd),
		.wen_i        (ex_wen),
		.is_load_i    (ex_is_load),
		.is_store_i   (ex_is_store),
		.size_i       (ex_size),
		.wmask_i      (ex_wmask),
		.store_data_i (ex_store_data),
		.ebreak_i     (ex_ebreak),
		.mul_busy_i   (mul_busy),
		.mul_done_i   (mul_done),
		.vld_o        (mem_vld),
		.res_o        (mem_addr),
		.rd_o         (mem_rd),
		.wen_o        (mem_wen),
		.is_load_o    (mem_is_load),
		.is_store_o   (mem_is_store),
		.size_o       (mem_size),
		.wmask_o      (mem_wmask),
		.store_data_o (mem_data),
		.ebreak_o     (mem_ebreak),
		.pend_o       (mem_pend)
	);

	rv_result #(
		.DMEM_WORDS (DMEM_WORDS)
	) u_result (
		.clk        (clk),
		.rst_n      (rst_n),
		.vld_i      (mem_vld),
		.addr_i     (mem_addr),
		.data_i     (mem_data),
		.rd_i       (mem_rd),
		.wen_i      (mem_wen),
		.is_load_i  (mem_is_load),
		.is_store_i (mem_is_store),
		.size_i     (mem_size),
		.wmask_i    (mem_wmask),
		.ebreak_i   (mem_ebreak),
		.wb_vld_o   (wb_vld_o),
		.wb_rd_o    (wb_rd_o),
		.wb_data_o  (wb_data_o),
		.halt_o     (halt_o)
	);

endmodule

//--- dv/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

localparam logic [2:0] F3_WORD   = 3'b010;
localparam logic [2:0] F3_DOUBLE = 3'b011;

// architectural state of the model, one step per accepted instruction
xlen_t       model_regs [32];
xlen_t       model_mem [DMEM_WORDS];
logic        model_halted;
reg_addr_t   exp_rd_q [$];   // expected write-backs in program order
xlen_t       exp_data_q [$];
logic [15:0] lfsr_state;

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [63:0] rand_bits(int n);
	logic [63:0] v;
	v = '0;
	for (int k = 0; k < n; k++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[62:0], lfsr_state[0]};
	end
	return v;
endfunction

function automatic reg_addr_t any_reg();
	return reg_addr_t'(rand_bits(3)); // x0..x7
endfunction

function automatic reg_addr_t live_reg();
	return reg_addr_t'(1 + rand_bits(3) % 7); // x1..x7
endfunction

function automatic instr_u rtype_word(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
	reg_addr_t rs1, reg_addr_t rs2);
	instr_u w;
	w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP};
	return w;
endfunction

function automatic instr_u itype_word(opcode_t op, logic [2:0] f3, reg_addr_t rd,
	reg_addr_t rs1, logic [11:0] imm);
	instr_u w;
	w.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: op};
	return w;
endfunction

function automatic instr_u stype_word(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
	logic [11:0] imm);
	instr_u w;
	w.s = '{imm_hi: imm[11:5], rs2: rs2, rs1: rs1, funct3: f3, imm_lo: imm[4:0],
		opcode: OPC_STORE};
	return w;
endfunction

function automatic instr_u alu_instr(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
	logic [11:0] imm;
	int          pick;
	imm  = 12'(rand_bits(12));
	pick = int'(rand_bits(4)) % 13;
	case (pick)
		0:  return rtype_word(7'h00, F3_ADD, rd, rs1, rs2);
		1:  return rtype_word(FUNCT7_ALT, F3_ADD, rd, rs1, rs2); // sub
		2:  return rtype_word(7'h00, F3_AND, rd, rs1, rs2);
		3:  return rtype_word(7'h00, F3_OR, rd, rs1, rs2);
		4:  return rtype_word(7'h00, F3_XOR, rd, rs1, rs2);
		5:  return rtype_word(7'h00, F3_SLL, rd, rs1, rs2);
		6:  return rtype_word(7'h00, F3_SRL, rd, rs1, rs2);
		7:  return rtype_word(FUNCT7_ALT, F3_SRL, rd, rs1, rs2); // sra
		8:  return rtype_word(7'h00, F3_SLT, rd, rs1, rs2);
		9:  return itype_word(OPC_OP_IMM, F3_ADD, rd, rs1, imm);
		10: return itype_word(OPC_OP_IMM, F3_XOR, rd, rs1, imm);
		11: return itype_word(OPC_OP_IMM, F3_OR, rd, rs1, imm);
		default: return itype_word(OPC_OP_IMM, F3_AND, rd, rs1, imm);
	endcase
endfunction

function automatic instr_u mul_instr(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
	return rtype_word(FUNCT7_MULDIV, F3_ADD, rd, rs1, rs2);
endfunction

// x0-based access to a random slot, kind 0 sd, 1 sw, 2 ld, 3 lw
function automatic instr_u mem_instr();
	int          kind;
	int          slot;
	logic [11:0] off;
	reg_addr_t   r;
	kind = int'(rand_bits(2));
	slot = int'(rand_bits(6)) % DMEM_WORDS;
	off  = 12'(slot * 8);
	if (kind == 1 || kind == 3) begin
		off = off + 12'(4 * rand_bits(1)); // upper or lower half
	end
	r = (kind < 2) ? live_reg() : any_reg();
	case (kind)
		0:  return stype_word(F3_DOUBLE, '0, r, off);
		1:  return stype_word(F3_WORD, '0, r, off);
		2:  return itype_word(OPC_LOAD, F3_DOUBLE, r, '0, off);
		default: return itype_word(OPC_LOAD, F3_WORD, r, '0, off);
	endcase
endfunction

function automatic void model_exec(instr_u w);
	xlen_t       a;
	xlen_t       b;
	xlen_t       imm;
	xlen_t       addr;
	xlen_t       res;
	logic [31:0] word;
	logic        alt;
	logic        wr;
	int          slot;
	if (model_halted) begin
		return;
	end
	a   = model_regs[w.r.rs1];
	b   = model_regs[w.r.rs2];
	alt = (w.r.funct7 == FUNCT7_ALT);
	res = '0;
	wr  = 1'b1;
	case (w.r.opcode)
		OPC_OP: begin
			if (w.r.funct7 == FUNCT7_MULDIV) begin
				res = a * b; // low 64 bits
			end else if (w.r.funct3 == F3_ADD) begin
				res = alt ? a - b : a + b;
			end else if (w.r.funct3 == F3_SLL) begin
				res = a << b[5:0];
			end else if (w.r.funct3 == F3_SLT) begin
				res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			end else if (w.r.funct3 == F3_XOR) begin
				res = a ^ b;
			end else if (w.r.funct3 == F3_SRL && alt) begin
				res = $signed(a) >>> b[5:0];
			end else if (w.r.funct3 == F3_SRL) begin
				res = a >> b[5:0];
			end else if (w.r.funct3 == F3_OR) begin
				res = a | b;
			end else begin
				res = a & b;
			end
		end
		OPC_OP_IMM: begin
			imm = {{52{w.i.imm[11]}}, w.i.imm};
			case (w.i.funct3)
				F3_ADD:  res = a + imm;
				F3_XOR:  res = a ^ imm;
				F3_OR:   res = a | imm;
				default: res = a & imm;
			endcase
		end
		OPC_LOAD: begin
			addr = a + {{52{w.i.imm[11]}}, w.i.imm};
			slot = int'(addr >> 3) % DMEM_WORDS;
			word = addr[2] ? model_mem[slot][63:32] : model_mem[slot][31:0];
			res  = (w.i.funct3 == F3_DOUBLE) ? model_mem[slot] : {{32{word[31]}}, word};
		end
		OPC_STORE: begin
			wr   = 1'b0;
			addr = a + {{52{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
			slot = int'(addr >> 3) % DMEM_WORDS;
			if (w.s.funct3 == F3_DOUBLE) begin
				model_mem[slot] = b;
			end else if (addr[2]) begin
				model_mem[slot][63:32] = b[31:0];
			end else begin
				model_mem[slot][31:0] = b[31:0];
			end
		end
		default: begin // ebreak, nothing after it retires
			wr           = 1'b0;
			model_halted = 1'b1;
		end
	endcase
	if (wr && w.r.rd != '0) begin
		model_regs[w.r.rd] = res;
		exp_rd_q.push_back(w.r.rd);
		exp_data_q.push_back(res);
	end
endfunction

`endif

//--- dv/rv_core_tb.sv
module rv_core_tb import rv_core_pkg::*; ();

	localparam int DMEM_WORDS  = 32;
	localparam int MUL_STEP    = 8;
	localparam int RST_CYCLES  = 16;
	localparam int N_INIT      = 7;
	localparam int N_ALU       = 200;
	localparam int N_CHAIN     = 60;
	localparam int N_MUL       = 60;
	localparam int N_MEM       = 60;
	localparam int N_X0        = 5;
	localparam int N_HALT      = 50;
	localparam int N_INSTR     = N_INIT + N_ALU + N_CHAIN + N_MUL + DMEM_WORDS + N_MEM
		+ N_X0 + N_HALT;
	localparam int PIPE_CYCLES = 4 + 64 / MUL_STEP + 4; // worst case per instruction
	localparam int CYCLE_LIMIT = N_INSTR * PIPE_CYCLES + RST_CYCLES;
	localparam int DRAIN_LIMIT = 64;

	logic      clk;
	logic      rst_n;
	logic      instr_vld;
	instr_u    instr;
	logic      stall;
	logic      wb_vld;
	reg_addr_t wb_rd;
	xlen_t     wb_data;
	logic      halt;

	string test_name;
	int    err_cnt;
	int    wb_cnt;
	int    test_err_base;
	int    test_wb_base;
	int    tests_run;
	int    tests_failed;
	int    cycle_cnt;

	`include "rv_ref_model.svh"

	rv_core_top #(
		.DMEM_WORDS (DMEM_WORDS),
		.MUL_STEP   (MUL_STEP)
	) dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_vld_i (instr_vld),
		.instr_i     (instr),
		.stall_o     (stall),
		.wb_vld_o    (wb_vld),
		.wb_rd_o     (wb_rd),
		.wb_data_o   (wb_data),
		.halt_o      (halt)
	);

	always #50 clk = ~clk;

	task automatic rd_check(reg_addr_t exp, reg_addr_t act);
		if (act !== exp) begin
			$display("Fail %s rd: expected x%0d, actual x%0d", test_name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic data_check(xlen_t exp, xlen_t act);
		if (act !== exp) begin
			$display("Fail %s data: expected %h, actual %h", test_name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic flag_check(string what, logic exp, logic act);
		if (act !== exp) begin
			$display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
			err_cnt++;
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (rst_n && wb_vld) begin
			if (exp_rd_q.size() == 0) begin
				$display("%s: write-back to x%0d that the model did not expect", test_name, wb_rd);
				err_cnt++;
			end else begin
				rd_check(exp_rd_q.pop_front(), wb_rd);
				data_check(exp_data_q.pop_front(), wb_data);
				wb_cnt++;
			end
		end
	end

	// held on the pins until an edge with stall low takes it
	task automatic issue(instr_u w);
		instr_vld <= 1'b1;
		instr     <= w;
		@(posedge clk);
		while (stall) begin
			@(posedge clk);
		end
		model_exec(w);
	endtask

	task automatic drain();
		int n;
		instr_vld <= 1'b0;
		n = 0;
		while (exp_rd_q.size() > 0 && n < DRAIN_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (exp_rd_q.size() > 0) begin
			$display("%s: %0d expected write-backs never left the pipeline", test_name,
				exp_rd_q.size());
			err_cnt++;
			exp_rd_q.delete();
			exp_data_q.delete();
		end
		repeat (PIPE_CYCLES) @(posedge clk); // room for a stray extra write-back
	endtask

	task automatic begin_test(string name);
		test_name     = name;
		test_err_base = err_cnt;
		test_wb_base  = wb_cnt;
	endtask

	task automatic end_test();
		int errs;
		errs = err_cnt - test_err_base;
		tests_run++;
		if (errs == 0) begin
			$display("test %s: ok, %0d write-backs", test_name, wb_cnt - test_wb_base);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, errs);
		end
	endtask

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles in %s, the pipeline stopped producing results",
			cycle_cnt, test_name);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		reg_addr_t   rd;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		logic [11:0] imm;
		int          sel;
		int          n;
		clk          = 1'b0;
		rst_n        = 1'b0;
		instr_vld    = 1'b0;
		instr        = '0;
		lfsr_state   = 16'd30;
		model_halted = 1'b0;
		err_cnt      = 0;
		wb_cnt       = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_name    = "reset";
		foreach (model_regs[k]) model_regs[k] = '0;
		foreach (model_mem[k]) model_mem[k] = '0;

		begin_test("reset");
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		flag_check("stall_o", 1'b0, stall); // idle pipeline right after reset
		flag_check("wb_vld_o", 1'b0, wb_vld);
		flag_check("halt_o", 1'b0, halt);
		end_test();
		@(posedge clk);

		begin_test("alu_random");
		for (int k = 1; k <= N_INIT; k++) begin // regfile has no reset
			imm = 12'(rand_bits(12));
			issue(itype_word(OPC_OP_IMM, F3_ADD, reg_addr_t'(k), '0, imm));
		end
		for (int k = 0; k < N_ALU; k++) begin
			rd  = any_reg();
			rs1 = any_reg();
			rs2 = any_reg();
			issue(alu_instr(rd, rs1, rs2));
		end
		drain();
		end_test();

		begin_test("dep_chain");
		rd = live_reg();
		for (int k = 0; k < N_CHAIN; k++) begin
			sel = int'(rand_bits(1));
			rs1 = rd;
			rs2 = any_reg();
			if (sel == 1) begin
				rs2 = rd;
			end
			rd = live_reg();
			issue(alu_instr(rd, rs1, rs2));
		end
		drain();
		end_test();

		begin_test("mul_hold");
		for (int k = 0; k < N_MUL; k++) begin
			sel = int'(rand_bits(2));
			rs1 = any_reg();
			rs2 = any_reg();
			if (sel == 3) begin
				rs1 = rd; // lean on the last result
			end
			rd = live_reg();
			if (sel < 2) begin
				issue(mul_instr(rd, rs1, rs2));
			end else begin
				issue(alu_instr(rd, rs1, rs2));
			end
		end
		drain();
		end_test();

		begin_test("load_store");
		for (int k = 0; k < DMEM_WORDS; k++) begin // every slot defined first
			issue(stype_word(F3_DOUBLE, '0, reg_addr_t'(1 + k % 7), 12'(k * 8)));
		end
		for (int k = 0; k < N_MEM; k++) begin
			issue(mem_instr());
		end
		drain();
		end_test();

		begin_test("x0_halt");
		issue(itype_word(OPC_OP_IMM, F3_ADD, '0, 5'd1, 12'h123));
		issue(rtype_word(7'h00, F3_ADD, '0, 5'd2, 5'd3));
		issue(rtype_word(7'h00, F3_OR, 5'd4, '0, '0)); // x0 reads as zero
		issue(itype_word(OPC_OP_IMM, F3_ADD, 5'd5, '0, 12'h7ff));
		issue(itype_word(OPC_SYSTEM, 3'b000, '0, '0, 12'd1)); // ebreak
		instr_vld <= 1'b0;
		n = 0;
		while (!halt && n < PIPE_CYCLES) begin
			@(posedge clk);
			n++;
		end
		if (!halt) begin
			$display("%s: halt_o did not rise after EBREAK", test_name);
			err_cnt++;
		end
		for (int k = 0; k < N_HALT; k++) begin
			sel = int'(rand_bits(2));
			rd  = live_reg();
			rs1 = any_reg();
			rs2 = any_reg();
			if (sel == 0) begin
				issue(mul_instr(rd, rs1, rs2));
			end else if (sel == 1) begin
				issue(mem_instr());
			end else begin
				issue(alu_instr(rd, rs1, rs2));
			end
		end
		drain();
		if (!halt) begin
			$display("%s: halt_o fell while instructions kept arriving", test_name);
			err_cnt++;
		end
		end_test();

		$display("%0d tests, %0d failed, %0d write-backs checked, %0d errors",
			tests_run, tests_failed, wb_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+dv
logic/rv_core_pkg.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_ex_mem_regs.sv
logic/rv_result.sv
logic/rv_core_top.sv
dv/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - logic/rv_core_pkg.sv
      - logic/rv_decode.sv
      - logic/rv_execute.sv
      - logic/rv_ex_mem_regs.sv
      - logic/rv_result.sv
      - logic/rv_core_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/rv_core_tb.sv
